// File: Makefile
VERILATOR ?= verilator
TOP ?= aesCtrCoreTb
BUILD_DIR ?= obj_dir
FILELIST ?= filelist.f
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Test completed successfully

SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv)
PATTERNS := testbench/aesCtrPatterns.hex
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(PATTERNS)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
source/aesMathPkg.sv
source/ctrModePkg.sv
source/ctrSequencer.sv
source/roundCounter.sv
source/nonceCounter.sv
source/keyExpander.sv
source/cipherRound.sv
source/aesCtrCore.sv
testbench/aesCtrCoreTb.sv

// File: source/aesCtrCore.sv
`timescale 1ns/1ps

module aesCtrCore import aesMathPkg::*, ctrModePkg::*; #(
  parameter int numRounds = 10
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  logic        start,
  input  logic        finish,
  input  aesBlockT    key,
  input  aesBlockT    wordIn,
  output logic        ready,
  output aesBlockT    wordOut,
  output logic [63:0] nonce
);

  cipherCtlT cipherCtl;
  roundInfoT roundInfo;
  ctrBlockT  ctrBlock;
  aesStateT  roundKey;
  logic      roundClear;
  logic      roundAdvance;
  logic      idle;

  // ##############################
  // Control
  // ##############################

  ctrSequencer #(.numRounds(numRounds)) i_ctrSequencer (
    .clk, .rst, .en, .start,
    .lastRound(roundInfo.lastRound),
    .cipherCtl, .roundClear, .roundAdvance, .idle, .ready
  );

  roundCounter #(.numRounds(numRounds)) i_roundCounter (
    .clk, .rst, .en, .roundClear, .roundAdvance, .roundInfo
  );

  nonceCounter i_nonceCounter (
    .clk, .rst, .en, .start, .finish, .idle, .ctrBlock
  );

  // ##############################
  // Datapath
  // ##############################

  keyExpander i_keyExpander (
    .clk, .rst, .en, .cipherCtl, .key,
    .rcon(roundInfo.rcon),
    .roundKey
  );

  cipherRound i_cipherRound (
    .clk, .rst, .en, .cipherCtl, .ctrBlock, .key, .wordIn, .roundKey, .wordOut, .nonce
  );

endmodule

// File: source/aesMathPkg.sv
package aesMathPkg;

  typedef logic [7:0] aesByteT;
  typedef aesByteT [3:0] aesWordT;     // One column, row r in byte r
  typedef aesWordT [3:0] aesStateT;    // Column-major, st[c][r] is block byte 4c+r
  typedef logic [127:0] aesBlockT;

  // ##############################
  // Substitution table
  // ##############################

  // Row is the high nibble, the first byte of each literal is low nibble 0
  localparam logic [0:15][0:15][7:0] sBoxTable = {
    128'h637c777b_f26b6fc5_3001672b_fed7ab76,
    128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
    128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
    128'h04c723c3_1896059a_071280e2_eb27b275,
    128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
    128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
    128'hd0efaafb_434d3385_45f9027f_503c9fa8,
    128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
    128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
    128'h60814fdc_222a9088_46eeb814_de5e0bdb,
    128'he0323a0a_4906245c_c2d3ac62_9195e479,
    128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
    128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
    128'h703eb566_4803f60e_613557b9_86c11d9e,
    128'he1f89811_69d98e94_9b1e87e9_ce5528df,
    128'h8ca1890d_bfe64268_41992d0f_b054bb16
  };

  function automatic aesByteT sBox(input aesByteT x);
    return sBoxTable[x[7:4]][x[3:0]];
  endfunction

  // ##############################
  // GF(2^8) arithmetic
  // ##############################

  function automatic aesByteT xTime(input aesByteT x);
    aesByteT shifted;
    shifted = {x[6:0], 1'b0};
    return x[7] ? (shifted ^ 8'h1b) : shifted;    // Reduce by x^8 + x^4 + x^3 + x + 1
  endfunction

  // Multiplies one column by the fixed MixColumns matrix
  function automatic aesWordT mixColumn(input aesWordT a);
    aesWordT twice;
    aesWordT thrice;
    aesWordT b;
    for (int r = 0; r < 4; r++) begin
      twice[r] = xTime(a[r]);
      thrice[r] = twice[r] ^ a[r];
    end
    b[0] = twice[0] ^ thrice[1] ^ a[2] ^ a[3];
    b[1] = a[0] ^ twice[1] ^ thrice[2] ^ a[3];
    b[2] = a[0] ^ a[1] ^ twice[2] ^ thrice[3];
    b[3] = thrice[0] ^ a[1] ^ a[2] ^ twice[3];
    return b;
  endfunction

endpackage

// File: source/cipherRound.sv
`timescale 1ns/1ps

module cipherRound import aesMathPkg::*, ctrModePkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  cipherCtlT   cipherCtl,
  input  ctrBlockT    ctrBlock,
  input  aesBlockT    key,
  input  aesBlockT    wordIn,
  input  aesStateT    roundKey,
  output aesBlockT    wordOut,
  output logic [63:0] nonce
);

  aesStateT cipherState;
  aesStateT subState;
  aesStateT shiftState;
  aesStateT mixState;
  aesStateT roundResult;
  logic     outPending;    // Keystream is final one cycle after the last round

  // ##############################
  // Round datapath
  // ##############################

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        subState[c][r] = sBox(cipherState[c][r]);
      end
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shiftState[c][r] = subState[(c + r) % 4][r];    // Row r rotates left by r
      end
    end
    for (int c = 0; c < 4; c++) begin
      mixState[c] = mixColumn(shiftState[c]);
    end
    roundResult = (cipherCtl.skipMix ? shiftState : mixState) ^ roundKey;
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (cipherCtl.load) cipherState <= aesStateT'(aesBlockT'(ctrBlock) ^ key);
      else if (cipherCtl.roundOp) cipherState <= roundResult;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      nonce <= '0;
      wordOut <= '0;
      outPending <= 1'b0;
    end else if (en) begin
      outPending <= cipherCtl.roundOp && cipherCtl.skipMix;
      if (cipherCtl.load) nonce <= ctrBlock.nonce;
      if (outPending) wordOut <= aesBlockT'(cipherState) ^ wordIn;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    !(cipherCtl.load && cipherCtl.roundOp));

endmodule

// File: source/ctrModePkg.sv
package ctrModePkg;

  // Counter in the low half of the block, IV in the high half
  typedef struct packed {
    logic [63:0] nonce;
    logic [63:0] blockCount;
  } ctrBlockT;

  localparam logic [63:0] ivResetValue = 64'habac1597df017863;
  localparam logic [63:0] ivXorMask = 64'ha0a0b0b0c1c1d2d2;
  localparam logic [63:0] ivAndMask = 64'hfff0fff0fff0ff0f;

  typedef enum logic [2:0] {
    seqIdle,
    seqLoad,
    seqKeyStep,
    seqRound,
    seqOutput
  } seqStateT;

  typedef struct packed {
    logic load;       // Load key and first key add
    logic keyStep;    // Advance round key
    logic roundOp;    // Apply one cipher round
    logic skipMix;    // Final round has no MixColumns
  } cipherCtlT;

  typedef struct packed {
    logic [7:0] rcon;
    logic       lastRound;
  } roundInfoT;

endpackage

// File: source/ctrSequencer.sv
`timescale 1ns/1ps

module ctrSequencer import ctrModePkg::*; #(
  parameter int numRounds = 10
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  logic      start,
  input  logic      lastRound,
  output cipherCtlT cipherCtl,
  output logic      roundClear,
  output logic      roundAdvance,
  output logic      idle,
  output logic      ready
);

  localparam int stepWidth = $clog2(2 * numRounds + 2);

  seqStateT state;
  seqStateT stateNext;
  logic [stepWidth-1:0] stepCount;    // Enabled cycles since leaving seqIdle

  // ##############################
  // State machine
  // ##############################

  always_comb begin
    stateNext = state;
    case (state)
      seqIdle:    if (start) stateNext = seqLoad;
      seqLoad:    stateNext = seqKeyStep;
      seqKeyStep: stateNext = seqRound;
      seqRound:   stateNext = lastRound ? seqOutput : seqKeyStep;
      seqOutput:  stateNext = seqIdle;
      default:    stateNext = seqIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= seqIdle;
      ready <= 1'b0;
      stepCount <= '0;
    end else if (en) begin
      state <= stateNext;
      if (state == seqLoad) ready <= 1'b0;
      else if (state == seqOutput) ready <= 1'b1;
      stepCount <= (state == seqIdle) ? '0 : stepCount + 1'b1;
    end
  end

  assign idle = (state == seqIdle);
  assign cipherCtl.load = (state == seqLoad);
  assign cipherCtl.keyStep = (state == seqKeyStep);
  assign cipherCtl.roundOp = (state == seqRound);
  assign cipherCtl.skipMix = (state == seqRound) && lastRound;
  assign roundClear = (state == seqLoad);
  assign roundAdvance = (state == seqRound) && !lastRound;    // Count stops at the last round

  // ##############################
  // Checks
  // ##############################

  assert property (@(posedge clk) disable iff (rst)
    $rose(ready) |-> $past(state) == seqOutput);

  // The round counter must flag the last round after exactly numRounds key/round pairs
  assert property (@(posedge clk) disable iff (rst)
    (state == seqOutput) |-> stepCount == stepWidth'(2 * numRounds + 1));

endmodule

// File: source/keyExpander.sv
`timescale 1ns/1ps

module keyExpander import aesMathPkg::*, ctrModePkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  cipherCtlT cipherCtl,
  input  aesBlockT  key,
  input  aesByteT   rcon,
  output aesStateT  roundKey
);

  aesWordT  rotWord;
  aesWordT  subWord;
  aesStateT nextKey;

  always_comb begin
    for (int r = 0; r < 4; r++) begin
      rotWord[r] = roundKey[3][(r + 1) % 4];    // RotWord of the last column
      subWord[r] = sBox(rotWord[r]);
    end
    nextKey[0] = roundKey[0] ^ subWord ^ aesWordT'({24'h0, rcon});
    for (int c = 1; c < 4; c++) begin
      nextKey[c] = roundKey[c] ^ nextKey[c-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      roundKey <= '0;
    end else if (en) begin
      if (cipherCtl.load) roundKey <= aesStateT'(key);
      else if (cipherCtl.keyStep) roundKey <= nextKey;
    end
  end

endmodule

// File: source/nonceCounter.sv
`timescale 1ns/1ps

module nonceCounter import ctrModePkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  input  logic     start,
  input  logic     finish,
  input  logic     idle,
  output ctrBlockT ctrBlock
);

  logic [63:0] iv;
  logic [63:0] count;
  logic        prepared;    // A new IV was derived by a lone finish
  logic [63:0] derivedIv;

  assign derivedIv = (iv ^ ivXorMask) & ivAndMask;

  // ##############################
  // Idle rules
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      iv <= ivResetValue;
      count <= '0;
      prepared <= 1'b0;
    end else if (en && idle) begin
      case ({finish, start})
        2'b10: begin
          if (!prepared) begin
            iv <= derivedIv;
            count <= '0;
            prepared <= 1'b1;
          end
        end
        2'b11: begin
          if (prepared) begin    // IV already fresh so only step the count
            count <= count + 1'b1;
            prepared <= 1'b0;
          end else begin
            iv <= derivedIv;
            count <= 64'd1;
          end
        end
        2'b01: begin
          count <= count + 1'b1;
          prepared <= 1'b0;
        end
        default: prepared <= 1'b0;
      endcase
    end
  end

  assign ctrBlock.nonce = iv;
  assign ctrBlock.blockCount = count;

endmodule

// File: source/roundCounter.sv
`timescale 1ns/1ps

module roundCounter import aesMathPkg::*, ctrModePkg::*; #(
  parameter int numRounds = 10
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  logic      roundClear,
  input  logic      roundAdvance,
  output roundInfoT roundInfo
);

  localparam int countWidth = $clog2(numRounds + 1);

  logic [countWidth-1:0] roundNum;
  aesByteT rcon;

  always_ff @(posedge clk) begin
    if (rst) begin
      roundNum <= countWidth'(1);
      rcon <= 8'h01;
    end else if (en) begin
      if (roundClear) begin
        roundNum <= countWidth'(1);
        rcon <= 8'h01;
      end else if (roundAdvance) begin
        roundNum <= roundNum + 1'b1;
        rcon <= xTime(rcon);    // 80 wraps to 1b then 36
      end
    end
  end

  assign roundInfo.rcon = rcon;
  assign roundInfo.lastRound = (roundNum == countWidth'(numRounds));

  // Relies on the sequencer holding off the advance in the last round
  assert property (@(posedge clk) disable iff (rst)
    roundNum >= countWidth'(1) && roundNum <= countWidth'(numRounds));

endmodule

// File: testbench/aesCtrCoreTb.sv
`timescale 1ns/1ps

module aesCtrCoreTb;

  localparam int clkPeriod = 8;
  localparam int numRecords = 9;
  localparam int maxGap = 7;
  localparam int gapAt = 5;                 // Cycle after the start edge where en drops
  localparam int baseLatency = 22;
  localparam int watchdogCycles = 4 + numRecords * (baseLatency + maxGap + 10);
  localparam logic [63:0] ivReset = 64'habac1597df017863;

  logic         clk;
  logic         rst;
  logic         en;
  logic         start;
  logic         finish;
  logic [127:0] key;
  logic [127:0] wordIn;
  logic         ready;
  logic [127:0] wordOut;
  logic [63:0]  nonce;

  logic [127:0] patMem [0:4*numRecords-1];  // Four words per record
  logic [31:0]  lfsr = 32'hb1f1_1ba2;
  logic [63:0]  trackIv;
  logic [63:0]  trackCount;

  aesCtrCore #(.numRounds(10)) i_aesCtrCore (
    .clk, .rst, .en, .start, .finish, .key, .wordIn, .ready, .wordOut, .nonce
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Watchdog expired before all records were processed");
    abortRun();
  end

  // ##############################
  // Reporting
  // ##############################

  task automatic abortRun();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  function automatic int drawBits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // Galois step
    end
    return value;
  endfunction

  // ##############################
  // AES reference model
  // ##############################

  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] aa;
    logic [7:0] bb;
    p = 8'h00;
    aa = a;
    bb = b;
    for (int i = 0; i < 8; i++) begin
      if (bb[0]) p = p ^ aa;
      aa = aa[7] ? ({aa[6:0], 1'b0} ^ 8'h1b) : {aa[6:0], 1'b0};
      bb = bb >> 1;
    end
    return p;
  endfunction

  // Multiplicative inverse followed by the affine transform
  function automatic logic [7:0] subByteRef(input logic [7:0] x);
    logic [7:0] inv;
    inv = 8'h00;
    for (int y = 1; y < 256; y++) begin
      if (gfMul(x, 8'(y)) == 8'h01) inv = 8'(y);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
           ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  // Byte 4c+r of a block sits at bits 8(4c+r)+7 down to 8(4c+r)
  function automatic logic [127:0] aesEncryptRef(input logic [127:0] k0,
                                                 input logic [127:0] pt);
    logic [127:0] s;
    logic [127:0] k;
    logic [127:0] nk;
    logic [127:0] ns;
    logic [7:0]   rc;
    logic [7:0]   t [4];
    logic [7:0]   a [4];
    s = pt ^ k0;
    k = k0;
    rc = 8'h01;
    for (int rnd = 1; rnd <= 10; rnd++) begin
      for (int r = 0; r < 4; r++) t[r] = subByteRef(k[8*(12 + (r + 1) % 4) +: 8]);
      t[0] = t[0] ^ rc;
      for (int r = 0; r < 4; r++) nk[8*r +: 8] = k[8*r +: 8] ^ t[r];
      for (int c = 1; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          nk[8*(4*c + r) +: 8] = k[8*(4*c + r) +: 8] ^ nk[8*(4*(c - 1) + r) +: 8];
        end
      end
      rc = gfMul(rc, 8'h02);
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          ns[8*(4*c + r) +: 8] = subByteRef(s[8*(4*((c + r) % 4) + r) +: 8]);
        end
      end
      if (rnd < 10) begin
        for (int c = 0; c < 4; c++) begin
          for (int r = 0; r < 4; r++) a[r] = ns[8*(4*c + r) +: 8];
          ns[8*(4*c) +: 8] = gfMul(a[0], 8'h02) ^ gfMul(a[1], 8'h03) ^ a[2] ^ a[3];
          ns[8*(4*c + 1) +: 8] = a[0] ^ gfMul(a[1], 8'h02) ^ gfMul(a[2], 8'h03) ^ a[3];
          ns[8*(4*c + 2) +: 8] = a[0] ^ a[1] ^ gfMul(a[2], 8'h02) ^ gfMul(a[3], 8'h03);
          ns[8*(4*c + 3) +: 8] = gfMul(a[0], 8'h03) ^ a[1] ^ a[2] ^ gfMul(a[3], 8'h02);
        end
      end
      s = ns ^ nk;
      k = nk;
    end
    return s;
  endfunction

  function automatic logic [63:0] deriveIv(input logic [63:0] iv);
    return (iv ^ 64'ha0a0b0b0c1c1d2d2) & 64'hfff0fff0fff0ff0f;
  endfunction

  // ##############################
  // Stimulus
  // ##############################

  task automatic waitForReady(input int idx, input int gapLen, input logic [127:0] prevOut);
    int   cycles;
    int   limit;
    logic sawLow;
    logic done;
    cycles = 0;
    limit = baseLatency + maxGap + 10;
    sawLow = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      cycles++;
      if (cycles == gapAt) en <= 1'b0;
      if (cycles == gapAt + gapLen) en <= 1'b1;  // Zero gap keeps en high
      @(negedge clk);
      if (!ready) begin
        sawLow = 1'b1;
        checkValue($sformatf("record %0d wordOut held", idx), prevOut, wordOut);
        checkValue($sformatf("record %0d nonce held", idx), 128'(trackIv), 128'(nonce));
      end else if (sawLow) begin
        done = 1'b1;
      end
      if (!done && cycles > limit) begin
        $display("Timed out waiting for ready in record %0d", idx);
        abortRun();
      end
    end
    checkValue($sformatf("record %0d ready latency", idx), 128'(baseLatency + gapLen),
               128'(cycles));
  endtask

  task automatic runRecord(input int idx);
    logic [7:0]   op;
    logic [127:0] recKey;
    logic [127:0] data;
    logic [127:0] fileWord;
    logic [127:0] expectedOut;
    logic [127:0] prevOut;
    int           gapLen;
    op = patMem[4*idx][7:0];
    recKey = patMem[4*idx + 1];
    data = patMem[4*idx + 2];
    fileWord = patMem[4*idx + 3];
    if (op == 8'h00) begin
      checkValue($sformatf("record %0d known answer", idx), fileWord,
                 aesEncryptRef(recKey, data));
      return;
    end
    if (op == 8'h01) begin
      trackCount = trackCount + 64'd1;
    end else begin
      trackIv = deriveIv(trackIv);
      trackCount = 64'd1;
    end
    checkValue($sformatf("record %0d file nonce", idx), fileWord, 128'(trackIv));
    expectedOut = aesEncryptRef(recKey, {trackIv, trackCount}) ^ data;
    prevOut = wordOut;
    @(posedge clk);
    key <= recKey;
    wordIn <= data;
    if (op == 8'h02) begin
      finish <= 1'b1;
      @(posedge clk);
      finish <= 1'b0;
      start <= 1'b1;
    end else begin
      start <= 1'b1;
      finish <= (op == 8'h03);
    end
    @(posedge clk);                               // DUT samples start here
    start <= 1'b0;
    finish <= 1'b0;
    gapLen = drawBits(3);
    waitForReady(idx, gapLen, prevOut);
    checkValue($sformatf("record %0d nonce", idx), 128'(trackIv), 128'(nonce));
    checkValue($sformatf("record %0d wordOut", idx), expectedOut, wordOut);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    rst = 1'b1;
    en = 1'b0;
    start = 1'b0;
    finish = 1'b0;
    key = '0;
    wordIn = '0;
    trackIv = ivReset;
    trackCount = 64'd0;
    $readmemh("testbench/aesCtrPatterns.hex", patMem);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    en <= 1'b1;
    @(negedge clk);
    checkValue("reset ready", 128'(0), 128'(ready));
    checkValue("reset wordOut", 128'(0), wordOut);
    checkValue("reset nonce", 128'(0), 128'(nonce));
    for (int i = 0; i < numRecords; i++) runRecord(i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: testbench/aesCtrPatterns.hex
// Columns: op key data expect. Op 1 plain start, 2 finish then start, 3 finish with start
// Op 0 checks the reference AES: data is plaintext, expect is ciphertext; else data=wordIn, expect=nonce
00 0f0e0d0c0b0a09080706050403020100 ffeeddccbbaa99887766554433221100 5ac5b47080b7cdd830047b6ad8e0c469
01 2b7e151628aed2a6abf7158809cf4f3c 00000000000000000000000000000000 abac1597df017863
01 2b7e151628aed2a6abf7158809cf4f3c 00112233445566778899aabbccddeeff abac1597df017863
01 000102030405060708090a0b0c0d0e0f ffffffffffffffffffffffffffffffff abac1597df017863
02 2b7e151628aed2a6abf7158809cf4f3c 0123456789abcdeffedcba9876543210 0b00a5201ec0aa01
01 2b7e151628aed2a6abf7158809cf4f3c 00000000000000000000000000000000 0b00a5201ec0aa01
03 000102030405060708090a0b0c0d0e0f 55555555555555555555555555555555 aba01590df007803
03 000102030405060708090a0b0c0d0e0f 00000000000000000000000000000000 0b00a5201ec0aa01
01 2b7e151628aed2a6abf7158809cf4f3c a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0b00a5201ec0aa01
